// File: rtl/im2col_macros.svh
`ifndef IM2COL_MACROS_SVH
`define IM2COL_MACROS_SVH

// DMA register block map
`define IM2COL_DMA_BASE       32'h0003_0000
`define IM2COL_DMA_CH_SIZE    32'h0000_0100
`define IM2COL_DMA_CH_NUM     4

`define IM2COL_FIFO_DEPTH     4  // Descriptors queued ahead of the loader

// Per-channel register offsets
`define IM2COL_OFS_SRC_PTR     32'h00
`define IM2COL_OFS_DST_PTR     32'h04
`define IM2COL_OFS_SIZE_D1     32'h0C
`define IM2COL_OFS_SIZE_D2     32'h10
`define IM2COL_OFS_INC_SRC_D1  32'h18
`define IM2COL_OFS_INC_SRC_D2  32'h1C
`define IM2COL_OFS_TOP_PAD     32'h3C
`define IM2COL_OFS_BOTTOM_PAD  32'h40
`define IM2COL_OFS_RIGHT_PAD   32'h44
`define IM2COL_OFS_LEFT_PAD    32'h48

`endif

// File: rtl/im2col_pkg.sv
`include "im2col_macros.svh"

package im2col_pkg;

  localparam int unsigned ChIdxW = (`IM2COL_DMA_CH_NUM > 1) ? $clog2(`IM2COL_DMA_CH_NUM) : 1;

  typedef logic [ChIdxW-1:0] ch_idx_t;

  typedef struct packed {
    logic [31:0] src_ptr;      // Byte address of the input tensor
    logic [31:0] dst_ptr;      // Byte address of the column buffer
    logic [15:0] iw;
    logic [15:0] ih;
    logic [7:0]  fw;
    logic [7:0]  fh;
    logic [7:0]  num_ch;
    logic [7:0]  batch;
    logic [7:0]  stride_d1;
    logic [7:0]  stride_d2;
    logic [5:0]  pad_top;
    logic [5:0]  pad_bottom;
    logic [5:0]  pad_left;
    logic [5:0]  pad_right;
    logic [15:0] n_patches_w;
    logic [15:0] n_patches_h;
  } im2col_cfg_t;

  typedef struct packed {
    logic [31:0] src_ptr;
    logic [31:0] dst_ptr;
    logic [31:0] inc_src_d1;   // Copy of stride_d1
    logic [31:0] inc_src_d2;
    logic [31:0] n_zeros_top;
    logic [31:0] n_zeros_bottom;
    logic [31:0] n_zeros_left;
    logic [31:0] n_zeros_right;
    logic [31:0] size_d1;
    logic [31:0] size_d2;
  } im2col_desc_t;

  typedef struct packed {
    logic [15:0] w_offset;
    logic [15:0] h_offset;
    logic [15:0] im_c;
    logic [15:0] batch_idx;
  } im2col_offsets_t;

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef enum logic [2:0] {
    P_IDLE,
    P_FMIN,
    P_COORD,
    P_ZEROS,
    P_SIZE,
    P_PTR,
    P_PUSH
  } param_state_e;

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_ACK,
    L_POP
  } load_state_e;

endpackage

// File: rtl/im2col_offset_counter.sv
`timescale 1ns/100ps

module im2col_offset_counter import im2col_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  im2col_cfg_t     cfg_i,
  input  logic            clear_i,
  input  logic            step_i,
  output im2col_offsets_t offs_o,
  output logic            last_o
);

  im2col_offsets_t offs_q;
  logic            b_last;
  logic            w_last;
  logic            h_last;
  logic            c_last;

  assign b_last = offs_q.batch_idx == 16'(cfg_i.batch) - 16'd1;
  assign w_last = offs_q.w_offset == 16'(cfg_i.fw) - 16'd1;
  assign h_last = offs_q.h_offset == 16'(cfg_i.fh) - 16'd1;
  assign c_last = offs_q.im_c == 16'(cfg_i.num_ch) - 16'd1;

  // Batch is innermost, then w, then h, channel outermost
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q <= '0;
    end else if (clear_i) begin
      offs_q <= '0;
    end else if (step_i) begin
      if (b_last) begin
        offs_q.batch_idx <= '0;
        if (w_last) begin
          offs_q.w_offset <= '0;
          if (h_last) begin
            offs_q.h_offset <= '0;
            offs_q.im_c     <= offs_q.im_c + 16'd1;
          end else begin
            offs_q.h_offset <= offs_q.h_offset + 16'd1;
          end
        end else begin
          offs_q.w_offset <= offs_q.w_offset + 16'd1;
        end
      end else begin
        offs_q.batch_idx <= offs_q.batch_idx + 16'd1;
      end
    end
  end

  assign offs_o = offs_q;
  assign last_o = b_last && w_last && h_last && c_last;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(step_i && clear_i));

endmodule

// File: rtl/im2col_param_fsm.sv
`timescale 1ns/100ps

module im2col_param_fsm import im2col_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  im2col_cfg_t     cfg_i,
  input  logic            start_i,
  input  im2col_offsets_t offs_i,
  input  logic            last_i,
  output logic            step_o,
  output logic            clear_o,
  input  logic            fifo_full_i,
  output logic            push_o,
  output im2col_desc_t    desc_o,
  output logic            plan_done_o
);

  param_state_e state_q;
  param_state_e state_d;
  logic         plan_done_q;
  logic [31:0]  fw_min_w_q;
  logic [31:0]  fh_min_h_q;
  logic [31:0]  im_row_q;
  logic [31:0]  im_col_q;
  logic [31:0]  zeros_top_q;
  logic [31:0]  zeros_bottom_q;
  logic [31:0]  zeros_left_q;
  logic [31:0]  zeros_right_q;
  logic [31:0]  size_d1_q;
  logic [31:0]  size_d2_q;
  logic [31:0]  index_q;
  logic [31:0]  src_ptr_q;
  logic [31:0]  inc_src_d2_q;
  logic [31:0]  dst_ptr_q;
  logic [31:0]  stride_d1;
  logic [31:0]  stride_d2;
  logic [31:0]  patch_bytes;

  function automatic logic [31:0] ceil_div(input logic [31:0] num, input logic [31:0] den);
    return (num + den - 32'd1) / den;
  endfunction

  assign stride_d1   = 32'(cfg_i.stride_d1);
  assign stride_d2   = 32'(cfg_i.stride_d2);
  assign patch_bytes = (32'(cfg_i.n_patches_h) * 32'(cfg_i.n_patches_w)) << 2;

  always_comb begin
    state_d = state_q;
    clear_o = 1'b0;
    push_o  = 1'b0;
    step_o  = 1'b0;
    unique case (state_q)
      P_IDLE: begin
        if (start_i) begin
          clear_o = 1'b1;  // Rewind offsets for a new job
          state_d = P_FMIN;
        end
      end
      P_FMIN:  state_d = P_COORD;
      P_COORD: state_d = P_ZEROS;
      P_ZEROS: state_d = P_SIZE;
      P_SIZE:  state_d = P_PTR;
      P_PTR: begin
        if (!fifo_full_i) begin
          state_d = P_PUSH;
        end
      end
      P_PUSH: begin
        push_o  = 1'b1;
        step_o  = !last_i;
        state_d = last_i ? P_IDLE : P_FMIN;
      end
      default: state_d = P_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= P_IDLE;
      plan_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == P_IDLE && start_i) begin
        plan_done_q <= 1'b0;
      end else if (push_o && last_i) begin
        plan_done_q <= 1'b1;
      end
    end
  end

  // Offsets stay put until the push cycle steps the counter
  always_ff @(posedge clk_i) begin
    unique case (state_q)
      P_IDLE:  dst_ptr_q <= cfg_i.dst_ptr;
      P_FMIN: begin
        fw_min_w_q <= 32'(cfg_i.fw) - 32'd1 - 32'(offs_i.w_offset);
        fh_min_h_q <= 32'(cfg_i.fh) - 32'd1 - 32'(offs_i.h_offset);
      end
      P_COORD: begin
        im_row_q <= 32'(offs_i.h_offset) - 32'(cfg_i.pad_top);  // May wrap negative
        im_col_q <= 32'(offs_i.w_offset) - 32'(cfg_i.pad_left);
      end
      P_ZEROS: begin
        zeros_top_q <= (32'(offs_i.h_offset) < 32'(cfg_i.pad_top)) ?
                       ceil_div(32'(cfg_i.pad_top) - 32'(offs_i.h_offset), stride_d2) : '0;
        zeros_left_q <= (32'(offs_i.w_offset) < 32'(cfg_i.pad_left)) ?
                        ceil_div(32'(cfg_i.pad_left) - 32'(offs_i.w_offset), stride_d1) : '0;
        zeros_bottom_q <= (fh_min_h_q < 32'(cfg_i.pad_bottom)) ?
                          ceil_div(32'(cfg_i.pad_bottom) - fh_min_h_q, stride_d2) : '0;
        zeros_right_q <= (fw_min_w_q < 32'(cfg_i.pad_right)) ?
                         ceil_div(32'(cfg_i.pad_right) - fw_min_w_q, stride_d1) : '0;
      end
      P_SIZE: begin
        size_d1_q <= 32'(cfg_i.n_patches_w) - zeros_left_q - zeros_right_q;
        size_d2_q <= 32'(cfg_i.n_patches_h) - zeros_top_q - zeros_bottom_q;
        index_q   <= ((32'(offs_i.batch_idx) * 32'(cfg_i.num_ch) + 32'(offs_i.im_c))
                     * 32'(cfg_i.ih) + im_row_q + zeros_top_q * stride_d2)
                     * 32'(cfg_i.iw) + im_col_q + zeros_left_q * stride_d1;
      end
      P_PTR: begin
        src_ptr_q    <= cfg_i.src_ptr + (index_q << 2);  // Word elements
        inc_src_d2_q <= stride_d2 * 32'(cfg_i.iw) - stride_d1 * (size_d1_q - 32'd1);
      end
      P_PUSH:  dst_ptr_q <= dst_ptr_q + patch_bytes;
      default: dst_ptr_q <= dst_ptr_q;
    endcase
  end

  assign desc_o.src_ptr        = src_ptr_q;
  assign desc_o.dst_ptr        = dst_ptr_q;
  assign desc_o.inc_src_d1     = stride_d1;
  assign desc_o.inc_src_d2     = inc_src_d2_q;
  assign desc_o.n_zeros_top    = zeros_top_q;
  assign desc_o.n_zeros_bottom = zeros_bottom_q;
  assign desc_o.n_zeros_left   = zeros_left_q;
  assign desc_o.n_zeros_right  = zeros_right_q;
  assign desc_o.size_d1        = size_d1_q;
  assign desc_o.size_d2        = size_d2_q;
  assign plan_done_o           = plan_done_q;

  // The FIFO full flag comes from another block, so check the push gating here
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_o && fifo_full_i));

endmodule

// File: rtl/im2col_desc_fifo.sv
`timescale 1ns/100ps
`include "im2col_macros.svh"

module im2col_desc_fifo #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned Depth = `IM2COL_FIFO_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PtrW + 1)'(push_i) - (PtrW + 1)'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];  // Head is visible without a pop
  assign full_o  = count_q == (PtrW + 1)'(Depth);
  assign empty_o = count_q == '0;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o));

endmodule

// File: rtl/im2col_dma_loader.sv
`timescale 1ns/100ps
`include "im2col_macros.svh"

module im2col_dma_loader import im2col_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  im2col_desc_t desc_i,
  input  logic         empty_i,
  output logic         pop_o,
  input  ch_idx_t      free_ch_i,
  input  logic         any_free_i,
  output logic         claim_o,
  output bus_req_t     bus_o,
  input  logic         bus_ack_i,
  output logic         idle_o
);

  load_state_e state_q;
  ch_idx_t     ch_q;
  logic [3:0]  idx_q;   // Register number within the descriptor
  bus_req_t    bus_q;
  logic [31:0] ch_base;
  logic [31:0] reg_ofs;
  logic [31:0] reg_data;

  assign ch_base = `IM2COL_DMA_BASE + 32'(ch_q) * `IM2COL_DMA_CH_SIZE;

  // Write order expected by the DMA channel
  always_comb begin
    unique case (idx_q)
      4'd0:    reg_ofs = `IM2COL_OFS_TOP_PAD;
      4'd1:    reg_ofs = `IM2COL_OFS_BOTTOM_PAD;
      4'd2:    reg_ofs = `IM2COL_OFS_LEFT_PAD;
      4'd3:    reg_ofs = `IM2COL_OFS_RIGHT_PAD;
      4'd4:    reg_ofs = `IM2COL_OFS_SRC_PTR;
      4'd5:    reg_ofs = `IM2COL_OFS_DST_PTR;
      4'd6:    reg_ofs = `IM2COL_OFS_INC_SRC_D1;
      4'd7:    reg_ofs = `IM2COL_OFS_INC_SRC_D2;
      4'd8:    reg_ofs = `IM2COL_OFS_SIZE_D2;
      default: reg_ofs = `IM2COL_OFS_SIZE_D1;  // Last write starts the channel
    endcase
  end

  always_comb begin
    unique case (idx_q)
      4'd0:    reg_data = desc_i.n_zeros_top;
      4'd1:    reg_data = desc_i.n_zeros_bottom;
      4'd2:    reg_data = desc_i.n_zeros_left;
      4'd3:    reg_data = desc_i.n_zeros_right;
      4'd4:    reg_data = desc_i.src_ptr;
      4'd5:    reg_data = desc_i.dst_ptr;
      4'd6:    reg_data = desc_i.inc_src_d1;
      4'd7:    reg_data = desc_i.inc_src_d2;
      4'd8:    reg_data = desc_i.size_d2;
      default: reg_data = desc_i.size_d1;
    endcase
  end

  assign claim_o = (state_q == L_IDLE) && !empty_i && any_free_i;
  assign pop_o   = state_q == L_POP;
  assign idle_o  = state_q == L_IDLE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= L_IDLE;
      ch_q    <= '0;
      idx_q   <= '0;
      bus_q   <= '0;
    end else begin
      unique case (state_q)
        L_IDLE: begin
          if (claim_o) begin
            ch_q    <= free_ch_i;
            idx_q   <= '0;
            state_q <= L_REQ;
          end
        end
        L_REQ: begin
          if (!bus_q.req) begin
            bus_q.req   <= 1'b1;
            bus_q.addr  <= ch_base + reg_ofs;
            bus_q.wdata <= reg_data;
          end else if (bus_ack_i) begin
            bus_q.req <= 1'b0;  // Addr and data held until ack drops
            state_q   <= L_ACK;
          end
        end
        L_ACK: begin
          if (!bus_ack_i) begin
            if (idx_q == 4'd9) begin
              state_q <= L_POP;
            end else begin
              idx_q   <= idx_q + 4'd1;
              state_q <= L_REQ;
            end
          end
        end
        L_POP:   state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  assign bus_o = bus_q;

  // Payload holds from the request until ack falls
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_q.req || bus_ack_i) |=> $stable(bus_q.addr) && $stable(bus_q.wdata));

  // Responder must have released ack before a new request
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(bus_q.req) |-> !bus_ack_i);

endmodule

// File: rtl/im2col_channel_tracker.sv
`timescale 1ns/100ps
`include "im2col_macros.svh"

module im2col_channel_tracker import im2col_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          claim_i,
  input  ch_idx_t                       claim_ch_i,
  input  logic [`IM2COL_DMA_CH_NUM-1:0] dma_done_i,
  output ch_idx_t                       free_ch_o,
  output logic                          any_free_o,
  output logic                          all_free_o
);

  localparam int unsigned ChNum = `IM2COL_DMA_CH_NUM;

  logic [ChNum-1:0] busy_q;
  logic [ChNum-1:0] busy_d;

  always_comb begin
    busy_d = busy_q & ~dma_done_i;  // Done pulse frees the channel
    if (claim_i) begin
      busy_d[claim_ch_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // Scan downwards so the lowest free index wins
  always_comb begin
    free_ch_o = '0;
    for (int i = ChNum - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_ch_o = ch_idx_t'(i);
      end
    end
  end

  assign any_free_o = ~&busy_q;
  assign all_free_o = ~|busy_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) claim_i |-> !busy_q[claim_ch_i]);

endmodule

// File: rtl/im2col_top.sv
`timescale 1ns/100ps
`include "im2col_macros.svh"

module im2col_top import im2col_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  im2col_cfg_t                   cfg_i,
  input  logic                          start_i,
  output bus_req_t                      bus_o,
  input  logic                          bus_ack_i,
  input  logic [`IM2COL_DMA_CH_NUM-1:0] dma_done_i,
  output logic                          busy_o,
  output logic                          done_o
);

  im2col_offsets_t offs;
  im2col_desc_t    desc_in;
  im2col_desc_t    desc_out;
  ch_idx_t         free_ch;
  logic            last;
  logic            step;
  logic            clear;
  logic            push;
  logic            pop;
  logic            fifo_full;
  logic            fifo_empty;
  logic            plan_done;
  logic            any_free;
  logic            all_free;
  logic            claim;
  logic            loader_idle;
  logic            busy_q;
  logic            done_q;

  im2col_param_fsm i_param_fsm (
    .clk_i,
    .rst_ni,
    .cfg_i,
    .start_i,
    .offs_i      (offs),
    .last_i      (last),
    .step_o      (step),
    .clear_o     (clear),
    .fifo_full_i (fifo_full),
    .push_o      (push),
    .desc_o      (desc_in),
    .plan_done_o (plan_done)
  );

  im2col_offset_counter i_offset_counter (
    .clk_i,
    .rst_ni,
    .cfg_i,
    .clear_i (clear),
    .step_i  (step),
    .offs_o  (offs),
    .last_o  (last)
  );

  im2col_desc_fifo #(
    .payload_t (im2col_desc_t)
  ) i_desc_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (push),
    .data_i  (desc_in),
    .full_o  (fifo_full),
    .pop_i   (pop),
    .data_o  (desc_out),
    .empty_o (fifo_empty)
  );

  im2col_dma_loader i_dma_loader (
    .clk_i,
    .rst_ni,
    .desc_i     (desc_out),
    .empty_i    (fifo_empty),
    .pop_o      (pop),
    .free_ch_i  (free_ch),
    .any_free_i (any_free),
    .claim_o    (claim),
    .bus_o,
    .bus_ack_i,
    .idle_o     (loader_idle)
  );

  // Loader always claims the channel the tracker offers
  im2col_channel_tracker i_channel_tracker (
    .clk_i,
    .rst_ni,
    .claim_i    (claim),
    .claim_ch_i (free_ch),
    .dma_done_i,
    .free_ch_o  (free_ch),
    .any_free_o (any_free),
    .all_free_o (all_free)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= busy_q && !done_q && plan_done && fifo_empty && loader_idle && all_free;
      if (done_q) begin
        busy_q <= 1'b0;  // Drops one cycle after the done pulse
      end else if (start_i) begin
        busy_q <= 1'b1;
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

endmodule

// File: tb/tb_im2col.sv
`timescale 1ns/100ps
`include "im2col_macros.svh"

module tb_im2col import im2col_pkg::*; ();

  localparam int unsigned ChNum       = `IM2COL_DMA_CH_NUM;
  localparam int unsigned RegsPerDesc = 10;
  localparam int unsigned OfsBase     = 1;     // Offsets follow the job count
  localparam int unsigned JobTimeout  = 8000;
  localparam int unsigned AckTimeout  = 50;
  localparam int unsigned StallCycles = 40;

  logic             clk;
  logic             rst_n;
  im2col_cfg_t      cfg;
  logic             start;
  bus_req_t         bus;
  logic             bus_ack;
  logic [ChNum-1:0] dma_done;
  logic             busy;
  logic             done;

  logic [31:0]      vec_mem [512];
  int unsigned      errors;
  int unsigned      checks;
  bit               aborted;
  int unsigned      job_idx;
  int unsigned      desc_base;
  int unsigned      exp_count;
  bit               hold_mode;   // Done pulses wait until every channel is loaded
  int unsigned      desc_seen;
  int unsigned      reg_idx;
  int unsigned      cur_ch;
  bit [ChNum-1:0]   ch_busy;
  int unsigned      held [$];
  logic             req_q;

  im2col_top i_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cfg_i      (cfg),
    .start_i    (start),
    .bus_o      (bus),
    .bus_ack_i  (bus_ack),
    .dma_done_i (dma_done),
    .busy_o     (busy),
    .done_o     (done)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic pulse_done(input int unsigned ch, input int unsigned delay);
    repeat (delay) @(posedge clk);
    ch_busy[ch] = 1'b0;
    dma_done[ch] <= 1'b1;
    @(posedge clk);
    dma_done[ch] <= 1'b0;
  endtask

  task automatic launch_done(input int unsigned ch);
    int unsigned delay;
    delay = $urandom_range(20, 1);
    fork
      pulse_done(ch, delay);
    join_none
  endtask

  task automatic release_held();
    int unsigned n;
    if (held.size() == ChNum && desc_seen < exp_count) begin
      // Every channel is loaded, so the loader has to sit still
      for (n = 0; n < StallCycles; n++) begin
        @(posedge clk);
        check_value($sformatf("job %0d req during stall", job_idx), 32'd0, 32'(bus.req));
      end
    end
    while (held.size() > 0) begin
      launch_done(held.pop_front());
    end
  endtask

  task automatic finish_descriptor(input int unsigned ch);
    if (hold_mode) begin
      held.push_back(ch);
      if (held.size() == ChNum || desc_seen == exp_count) begin
        release_held();
      end
    end else begin
      launch_done(ch);
    end
  endtask

  task automatic check_write(input logic [31:0] addr, input logic [31:0] data,
                             output bit desc_end);
    logic [31:0] rel;
    int unsigned ch;
    string       tag;
    rel      = addr - `IM2COL_DMA_BASE;
    ch       = rel / `IM2COL_DMA_CH_SIZE;
    tag      = $sformatf("job %0d desc %0d reg %0d", job_idx, desc_seen, reg_idx);
    desc_end = 1'b0;
    if (desc_seen >= exp_count) begin
      errors++;
      $display("Write to %h after the last expected descriptor of job %0d", addr, job_idx);
    end else begin
      if (reg_idx == 0) begin
        if (ch >= ChNum) begin
          errors++;
          $display("Write to %h hits no DMA channel", addr);
        end else if (ch_busy[ch]) begin
          errors++;
          $display("Channel %0d loaded again before its done pulse", ch);
        end else begin
          ch_busy[ch] = 1'b1;
        end
        cur_ch = ch;
      end else begin
        check_value({tag, " channel"}, cur_ch, ch);  // One channel per descriptor
      end
      check_value({tag, " offset"}, vec_mem[OfsBase + reg_idx], rel % `IM2COL_DMA_CH_SIZE);
      check_value({tag, " data"}, vec_mem[desc_base + desc_seen * RegsPerDesc + reg_idx], data);
      reg_idx++;
      if (reg_idx == RegsPerDesc) begin
        reg_idx  = 0;
        desc_seen++;
        desc_end = 1'b1;
      end
    end
  endtask

  task automatic serve_write();
    int unsigned delay;
    int unsigned n;
    bit          desc_end;
    delay = $urandom_range(5, 0);
    repeat (delay) @(posedge clk);
    check_write(bus.addr, bus.wdata, desc_end);
    bus_ack <= 1'b1;
    n = 0;
    while (bus.req && n < AckTimeout) begin
      @(posedge clk);
      n++;
    end
    if (bus.req) begin
      errors++;
      aborted = 1'b1;
      $display("Request was never withdrawn after ack");
    end
    bus_ack <= 1'b0;
    if (desc_end) begin
      finish_descriptor(cur_ch);
    end
  endtask

  // Bus responder
  initial begin : responder
    while (!aborted) begin
      @(posedge clk);
      if (rst_n && bus.req && !bus_ack) begin
        serve_write();
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && bus.req && !req_q) begin
      check_value("ack low when req rises", 32'd0, 32'(bus_ack));
    end
    req_q <= bus.req;
  end

  task automatic wait_done();
    int unsigned n;
    bit          seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < JobTimeout) begin
      @(posedge clk);
      n++;
      if (done) begin
        seen = 1'b1;
      end else begin
        check_value($sformatf("job %0d busy while running", job_idx), 32'd1, 32'(busy));
      end
    end
    if (!seen) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: job %0d never signalled done", job_idx);
    end
  endtask

  task automatic run_job(inout int unsigned ptr);
    im2col_cfg_t c;
    c.src_ptr     = vec_mem[ptr];
    c.dst_ptr     = vec_mem[ptr + 1];
    c.iw          = 16'(vec_mem[ptr + 2]);
    c.ih          = 16'(vec_mem[ptr + 3]);
    c.fw          = 8'(vec_mem[ptr + 4]);
    c.fh          = 8'(vec_mem[ptr + 5]);
    c.num_ch      = 8'(vec_mem[ptr + 6]);
    c.batch       = 8'(vec_mem[ptr + 7]);
    c.stride_d1   = 8'(vec_mem[ptr + 8]);
    c.stride_d2   = 8'(vec_mem[ptr + 9]);
    c.pad_top     = 6'(vec_mem[ptr + 10]);
    c.pad_bottom  = 6'(vec_mem[ptr + 11]);
    c.pad_left    = 6'(vec_mem[ptr + 12]);
    c.pad_right   = 6'(vec_mem[ptr + 13]);
    c.n_patches_w = 16'(vec_mem[ptr + 14]);
    c.n_patches_h = 16'(vec_mem[ptr + 15]);
    exp_count     = vec_mem[ptr + 16];
    hold_mode     = vec_mem[ptr + 17][0];
    desc_base     = ptr + 18;
    ptr           = desc_base + exp_count * RegsPerDesc;
    desc_seen     = 0;
    reg_idx       = 0;
    @(posedge clk);
    cfg   <= c;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    check_value($sformatf("job %0d busy after start", job_idx), 32'd1, 32'(busy));
    wait_done();
    if (!aborted) begin
      check_value($sformatf("job %0d descriptors", job_idx), exp_count, desc_seen);
      check_value($sformatf("job %0d partial writes", job_idx), 32'd0, reg_idx);
      check_value($sformatf("job %0d channels busy", job_idx), 32'd0, 32'(ch_busy));
      repeat (3) begin
        @(posedge clk);
        check_value($sformatf("job %0d done after pulse", job_idx), 32'd0, 32'(done));
        check_value($sformatf("job %0d busy after done", job_idx), 32'd0, 32'(busy));
      end
    end
  endtask

  initial begin : main
    int unsigned ptr;
    int unsigned num_jobs;
    void'($urandom(32'h15cd_4301));
    clk       = 1'b0;
    rst_n     = 1'b0;
    cfg       = '0;
    start     = 1'b0;
    bus_ack   = 1'b0;
    dma_done  = '0;
    errors    = 0;
    checks    = 0;
    aborted   = 1'b0;
    job_idx   = 0;
    desc_base = 0;
    exp_count = 0;
    hold_mode = 1'b0;
    desc_seen = 0;
    reg_idx   = 0;
    cur_ch    = 0;
    ch_busy   = '0;
    $readmemh("tb/im2col_vectors.txt", vec_mem);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("req after reset", 32'd0, 32'(bus.req));
    check_value("busy after reset", 32'd0, 32'(busy));
    check_value("done after reset", 32'd0, 32'(done));
    if ($isunknown(vec_mem[0])) begin
      errors++;
      $display("Vector file tb/im2col_vectors.txt could not be read");
    end else begin
      num_jobs = vec_mem[0];
      ptr      = OfsBase + RegsPerDesc;
      for (job_idx = 0; job_idx < num_jobs && !aborted; job_idx++) begin
        run_job(ptr);
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+rtl
rtl/im2col_pkg.sv
rtl/im2col_offset_counter.sv
rtl/im2col_param_fsm.sv
rtl/im2col_desc_fifo.sv
rtl/im2col_dma_loader.sv
rtl/im2col_channel_tracker.sv
rtl/im2col_top.sv
tb/tb_im2col.sv

// File: Bender.yml
package:
  name: im2col

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/im2col_pkg.sv
      - rtl/im2col_offset_counter.sv
      - rtl/im2col_param_fsm.sv
      - rtl/im2col_desc_fifo.sv
      - rtl/im2col_dma_loader.sv
      - rtl/im2col_channel_tracker.sv
      - rtl/im2col_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_im2col.sv

// File: tb/im2col_vectors.txt
// Word 0 is the job count, the next line holds the register offsets in write order
// Job: config (src dst iw ih fw fh num_ch batch stride_d1 stride_d2 pad_t pad_b pad_l pad_r
// npw nph), then descriptor count and hold flag, then one line per descriptor with the data
// of top bottom left right src dst inc_d1 inc_d2 size_d2 size_d1
3
3c 40 48 44 00 04 18 1c 10 0c
// Unpadded 2x2 filter, one channel, batch 1
10000000 20000000 4 4 2 2 1 1 1 1 0 0 0 0 3 3
4 0
0 0 0 0 10000000 20000000 1 2 3 3
0 0 0 0 10000004 20000024 1 2 3 3
0 0 0 0 10000010 20000048 1 2 3 3
0 0 0 0 10000014 2000006c 1 2 3 3
// Padded 3x3 filter, stride 2, uneven pads
10000000 30000000 6 6 3 3 1 1 2 2 2 1 1 2 4 4
9 0
1 0 1 0 10000004 30000000 2 8 3 3
1 0 0 1 10000000 30000040 2 8 3 3
1 0 0 1 10000004 30000080 2 8 3 3
1 0 1 0 1000001c 300000c0 2 8 3 3
1 0 0 1 10000018 30000100 2 8 3 3
1 0 0 1 1000001c 30000140 2 8 3 3
0 1 1 0 10000004 30000180 2 8 3 3
0 1 0 1 10000000 300001c0 2 8 3 3
0 1 0 1 10000004 30000200 2 8 3 3
// Two input channels, batch 2, done pulses held back until all channels are loaded
10000000 40000000 4 3 2 1 2 2 1 1 0 0 0 0 3 3
8 1
0 0 0 0 10000000 40000000 1 2 3 3
0 0 0 0 10000060 40000024 1 2 3 3
0 0 0 0 10000004 40000048 1 2 3 3
0 0 0 0 10000064 4000006c 1 2 3 3
0 0 0 0 10000030 40000090 1 2 3 3
0 0 0 0 10000090 400000b4 1 2 3 3
0 0 0 0 10000034 400000d8 1 2 3 3
0 0 0 0 10000094 400000fc 1 2 3 3
